// ==== Bender.yml ====
package:
  name: rv_decode

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_decode_pkg.sv
      - verilog/inst_classify.sv
      - verilog/imm_gen.sv
      - verilog/reg_use.sv
      - verilog/uop_route.sv
      - verilog/rv_decode.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verification/rv_decode_assertions.sv
      - verification/rv_decode_checker.sv
      - verification/rv_decode_tb.sv

// ==== rv_decode.f ====
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/inst_classify.sv
verilog/imm_gen.sv
verilog/reg_use.sv
verilog/uop_route.sv
verilog/rv_decode.sv
verification/rv_decode_assertions.sv
verification/rv_decode_checker.sv
verification/rv_decode_tb.sv

// ==== verification/rv_decode_assertions.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module rv_decode_assertions (
    input logic                     i_clk,
    input logic                     i_rst_n,
    input logic                     i_inst_valid,
    input logic                     i_dec_valid,
    input rv_decode_pkg::dec_info_s i_dec,
    input logic                     i_unknown
);

    int fail_cnt = 0;

    // one cycle of latency on the valid strobe
    a_valid_follows: assert property (@(posedge i_clk)
        $past(i_rst_n) |-> (i_dec_valid == $past(i_inst_valid)))
    else begin
        fail_cnt++;
        $error("o_dec_valid does not follow i_inst_valid of the previous cycle");
    end

    a_wen_rd_nz: assert property (@(posedge i_clk)
        i_dec.rd_wen |-> (i_dec.rd_idx != '0))
    else begin
        fail_cnt++;
        $error("rd_wen set with rd_idx x0");
    end

    a_unknown_route: assert property (@(posedge i_clk)
        i_unknown |-> ((i_dec.uop == rv_decode_pkg::uop_none) &&
                       (i_dec.disp_que == `DISP_UNKNOWN)))
    else begin
        fail_cnt++;
        $error("unknown instruction not routed to the unknown queue with uop none");
    end

    a_reset_clears_valid: assert property (@(posedge i_clk)
        !$past(i_rst_n) |-> !i_dec_valid)
    else begin
        fail_cnt++;
        $error("o_dec_valid high in the cycle after reset");
    end

endmodule

bind rv_decode rv_decode_assertions u_assertions (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_dec_valid  (o_dec_valid),
    .i_dec        (o_dec),
    .i_unknown    (o_unknown)
);

`default_nettype wire

// ==== verification/rv_decode_checker.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module rv_decode_checker (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_inst_valid,
    input  logic [`RV_ILEN-1:0]         i_inst,
    input  logic                        i_dec_valid,
    input  rv_decode_pkg::dec_info_s    i_dec,
    input  logic                        i_unknown,
    output int                          o_err_cnt,
    output int                          o_chk_cnt
);

    rv_decode_pkg::dec_info_s   exp_dec;
    rv_decode_pkg::dec_info_s   next_dec;
    logic                       exp_valid;
    logic                       exp_unknown;
    logic                       next_unknown;

    initial begin
        o_err_cnt = 0;
        o_chk_cnt = 0;
    end

    // reference decode straight from the ISA encoding tables
    task automatic model_decode(input logic [31:0] w, output rv_decode_pkg::dec_info_s d,
                                output logic unk);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [19:0] imm;
        logic        op, op32, opi, opi32, imm_m, int_m, word;
        logic        add, sub, shift, logic_op, cmp, mdu;
        logic        br, jal, jalr, lui, auipc, load, store, csr;
        f3    = w[14:12];
        f7    = w[31:25];
        op    = (w[6:0] == 7'b0110011);
        op32  = (w[6:0] == 7'b0111011);
        opi   = (w[6:0] == 7'b0010011);
        opi32 = (w[6:0] == 7'b0011011);
        imm_m = opi | opi32;
        word  = op32 | opi32;

        add = (f3 == 3'd0) & (((op | op32) & (f7 == 7'h00)) | imm_m);
        sub = (f3 == 3'd0) & (op | op32) & (f7 == 7'h20);
        // rv64 shift-immediates carry a 6 bit shamt
        if (opi) begin
            shift = ((f3 == 3'd1) & (w[31:26] == 6'h00)) |
                    ((f3 == 3'd5) & ((w[31:26] == 6'h00) | (w[31:26] == 6'h10)));
        end else begin
            shift = (op | op32 | opi32) & (((f3 == 3'd1) & (f7 == 7'h00)) |
                    ((f3 == 3'd5) & ((f7 == 7'h00) | (f7 == 7'h20))));
        end
        logic_op = ((f3 == 3'd4) | (f3 == 3'd6) | (f3 == 3'd7)) & ((op & (f7 == 7'h00)) | opi);
        cmp      = ((f3 == 3'd2) | (f3 == 3'd3)) & ((op & (f7 == 7'h00)) | opi);
        mdu      = (f7 == 7'h01) & (op | (op32 & ((f3 == 3'd0) | (f3 >= 3'd4))));
        br       = (w[6:0] == 7'b1100011) & (f3 != 3'd2) & (f3 != 3'd3);
        jal      = (w[6:0] == 7'b1101111);
        jalr     = (w[6:0] == 7'b1100111) & (f3 == 3'd0);
        lui      = (w[6:0] == 7'b0110111);
        auipc    = (w[6:0] == 7'b0010111);
        load     = (w[6:0] == 7'b0000011) & (f3 != 3'd7);
        store    = (w[6:0] == 7'b0100011) & (f3 <= 3'd3);
        csr      = (w[6:0] == 7'b1110011) & (f3 != 3'd0) & (f3 != 3'd4);
        int_m    = add | sub | shift | logic_op | cmp;
        unk      = !(int_m | br | jal | jalr | lui | auipc | load | store | csr | mdu);

        imm = (lui | auipc)         ? w[31:12] :
              br                    ? {{8{w[31]}}, w[7], w[30:25], w[11:8], 1'b0} :
              store                 ? {{8{w[31]}}, w[31:25], w[11:7]} :
              (imm_m & shift)       ? {14'd0, w[25:20]} :
              (load | jalr | imm_m) ? {{8{w[31]}}, w[31:20]} :
              jal                   ? {w[19:12], w[20], w[30:21], 1'b0} :
              csr                   ? {3'd0, w[31:15]} : 20'd0;

        d           = '0;
        d.imm20     = imm;
        d.rd_wen    = (lui | auipc | jal | jalr | imm_m | int_m | csr | load | mdu) &
                      (w[11:7] != 5'd0);
        d.rd_idx    = d.rd_wen ? w[11:7] : 5'd0;
        d.rs1_idx   = (lui | auipc | jal) ? 5'd0 : w[19:15];
        d.rs2_idx   = (br | store | mdu | (int_m & !imm_m)) ? w[24:20] : 5'd0;
        d.use_imm   = imm_m & (imm != 20'd0) & (w[11:7] != 5'd0);
        // addi rd, rd, 0 and add rd, rd, x0
        d.is_mv     = (w[11:7] == w[19:15]) & (f3 == 3'd0) &
                      ((opi & (w[31:20] == 12'd0)) | (op & (f7 == 7'h00) & (w[24:20] == 5'd0)));
        d.disp_que  = unk ? `DISP_UNKNOWN : (load | store) ? `DISP_MEM : `DISP_INT;
        d.issue_que = (int_m | imm_m) ? `ISSUE_ALU : mdu ? `ISSUE_MDU : `ISSUE_MISC;

        d.uop = rv_decode_pkg::uop_none;
        if (lui) begin
            d.uop = rv_decode_pkg::uop_lui;
        end else if (add | sub) begin
            case ({sub, word})
                2'b00:   d.uop = rv_decode_pkg::uop_add;
                2'b01:   d.uop = rv_decode_pkg::uop_addw;
                2'b10:   d.uop = rv_decode_pkg::uop_sub;
                default: d.uop = rv_decode_pkg::uop_subw;
            endcase
        end else if (shift) begin
            case ({f3[2], w[30], word})
                3'b000:  d.uop = rv_decode_pkg::uop_sll;
                3'b001:  d.uop = rv_decode_pkg::uop_sllw;
                3'b100:  d.uop = rv_decode_pkg::uop_srl;
                3'b101:  d.uop = rv_decode_pkg::uop_srlw;
                3'b110:  d.uop = rv_decode_pkg::uop_sra;
                3'b111:  d.uop = rv_decode_pkg::uop_sraw;
                default: d.uop = rv_decode_pkg::uop_none;
            endcase
        end else if (logic_op) begin
            d.uop = (f3 == 3'd4) ? rv_decode_pkg::uop_xor :
                    (f3 == 3'd6) ? rv_decode_pkg::uop_or : rv_decode_pkg::uop_and;
        end else if (cmp) begin
            d.uop = (f3 == 3'd3) ? rv_decode_pkg::uop_sltu : rv_decode_pkg::uop_slt;
        end else if (mdu) begin
            case ({word, f3})
                4'b0000: d.uop = rv_decode_pkg::uop_mul;
                4'b1000: d.uop = rv_decode_pkg::uop_mulw;
                4'b0001: d.uop = rv_decode_pkg::uop_mulh;
                4'b0010: d.uop = rv_decode_pkg::uop_mulhsu;
                4'b0011: d.uop = rv_decode_pkg::uop_mulhu;
                4'b0100: d.uop = rv_decode_pkg::uop_div;
                4'b1100: d.uop = rv_decode_pkg::uop_divw;
                4'b0101: d.uop = rv_decode_pkg::uop_divu;
                4'b0110: d.uop = rv_decode_pkg::uop_rem;
                4'b1110: d.uop = rv_decode_pkg::uop_remw;
                4'b0111: d.uop = rv_decode_pkg::uop_remu;
                4'b1111: d.uop = rv_decode_pkg::uop_remuw;
                // divuw has no micro-op
                default: d.uop = rv_decode_pkg::uop_none;
            endcase
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] expv,
                               input logic [31:0] actv);
        o_chk_cnt++;
        if (actv !== expv) begin
            o_err_cnt++;
            $display("** Error: %s expected 0x%h actual 0x%h at %0t", name, expv, actv, $time);
        end
    endtask

    // expected pipeline register on the DUT clock edge
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            exp_valid   <= 1'b0;
            exp_unknown <= 1'b0;
            exp_dec     <= '0;
        end else begin
            exp_valid <= i_inst_valid;
            if (i_inst_valid) begin
                model_decode(i_inst, next_dec, next_unknown);
                exp_dec     <= next_dec;
                exp_unknown <= next_unknown;
            end
        end
    end

    // outputs are settled mid-cycle
    always @(negedge i_clk) begin
        check_field("o_dec_valid", exp_valid, i_dec_valid);
        check_field("o_unknown", exp_unknown, i_unknown);
        check_field("o_dec.is_mv", exp_dec.is_mv, i_dec.is_mv);
        check_field("o_dec.imm20", exp_dec.imm20, i_dec.imm20);
        check_field("o_dec.rd_wen", exp_dec.rd_wen, i_dec.rd_wen);
        check_field("o_dec.rd_idx", exp_dec.rd_idx, i_dec.rd_idx);
        check_field("o_dec.rs1_idx", exp_dec.rs1_idx, i_dec.rs1_idx);
        check_field("o_dec.rs2_idx", exp_dec.rs2_idx, i_dec.rs2_idx);
        check_field("o_dec.use_imm", exp_dec.use_imm, i_dec.use_imm);
        check_field("o_dec.disp_que", exp_dec.disp_que, i_dec.disp_que);
        check_field("o_dec.issue_que", exp_dec.issue_que, i_dec.issue_que);
        check_field("o_dec.uop", exp_dec.uop, i_dec.uop);
        check_field("o_dec.pad", exp_dec.pad, i_dec.pad);
    end

endmodule

`default_nettype wire

// ==== verification/rv_decode_tb.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module rv_decode_tb;

    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 3000;
    // reset, stimulus, drain and some margin
    localparam int MAX_CYCLES   = RESET_CYCLES + TEST_CYCLES + 84;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       inst_valid;
    logic [`RV_ILEN-1:0]        inst;
    logic                       dec_valid;
    rv_decode_pkg::dec_info_s   dec;
    logic                       unknown;
    logic [`RV_ILEN-1:0]        next_inst;
    logic [6:0]                 known_opc [0:11];
    logic [6:0]                 dropped_opc [0:5];
    integer                     seed;
    int                         cycle_cnt;
    int                         err_cnt;
    int                         chk_cnt;
    int                         assert_cnt;

    always #50 clk = ~clk;

    rv_decode uut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_dec_valid  (dec_valid),
        .o_dec        (dec),
        .o_unknown    (unknown)
    );

    rv_decode_checker u_checker (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .i_dec_valid  (dec_valid),
        .i_dec        (dec),
        .i_unknown    (unknown),
        .o_err_cnt    (err_cnt),
        .o_chk_cnt    (chk_cnt)
    );

    task automatic make_inst(output logic [31:0] w);
        logic [31:0] sel;
        logic [31:0] f;
        sel = $random(seed);
        w   = $random(seed);
        f   = $random(seed);
        if (sel % 10 < 7) begin
            // known opcode, registers often x0..x3 so rd == rs1 and x0 show up
            w[6:0] = known_opc[f[3:0] % 12];
            w[11:7] = f[4] ? w[11:7] : {3'b000, w[8:7]};
            w[19:15] = f[5] ? w[19:15] : {3'b000, w[16:15]};
            w[24:20] = f[6] ? w[24:20] : {3'b000, w[21:20]};
            case (f[9:8])
                2'd0: w[31:25] = 7'h00;
                2'd1: w[31:25] = 7'h20;
                2'd2: w[31:25] = 7'h01;
                default: w[31:25] = w[31:25];
            endcase
            // shamt bit 5 on rv64 shift-immediates
            if (w[6:0] == 7'b0010011) begin
                w[25] = f[10];
            end
        end else if (sel % 10 < 9) begin
            if (f[2:0] > 3'd5) begin
                // compressed encodings
                w[1:0] = f[4:3] % 3;
            end else begin
                w[6:0] = dropped_opc[f[2:0]];
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        seed       = 72;
        cycle_cnt  = 0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        known_opc  = '{7'b0110011, 7'b0111011, 7'b0010011, 7'b0011011, 7'b0110111, 7'b0010111,
                       7'b1101111, 7'b1100111, 7'b1100011, 7'b0000011, 7'b0100011, 7'b1110011};
        // fp load, fp store, fp op, fma, amo, fence
        dropped_opc = '{7'b0000111, 7'b0100111, 7'b1010011, 7'b1000011, 7'b0101111,
                        7'b0001111};
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (TEST_CYCLES) begin
            make_inst(next_inst);
            inst       <= next_inst;
            inst_valid <= ($unsigned($random(seed)) % 10) < 8;
            @(posedge clk);
        end
        inst_valid <= 1'b0;
        repeat (3) @(posedge clk);
        assert_cnt = uut.u_assertions.fail_cnt;
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 chk_cnt, err_cnt, assert_cnt);
        if (err_cnt == 0 && assert_cnt == 0 && chk_cnt > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module imm_gen (
    input  rv_decode_pkg::inst_u        i_inst,
    input  rv_decode_pkg::inst_class_s  i_class,
    output logic [`RV_IMM_W-1:0]        o_imm20
);

    logic                       sign;
    logic [`RV_IMM_W-1:0]       imm_i;
    logic [`RV_IMM_W-1:0]       imm_s;
    logic [`RV_IMM_W-1:0]       imm_b;
    logic [`RV_IMM_W-1:0]       imm_u;
    logic [`RV_IMM_W-1:0]       imm_j;
    logic [`RV_IMM_W-1:0]       imm_shamt;
    logic [`RV_IMM_W-1:0]       imm_csr;
    logic [`RV_CSR_IDX_W-1:0]   csr_addr;

    assign sign     = i_inst.raw[`RV_ILEN-1];
    assign csr_addr = i_inst.i_fmt.imm_11_0;

    assign imm_i = {{8{sign}}, i_inst.i_fmt.imm_11_0};
    assign imm_s = {{8{sign}}, i_inst.s_fmt.imm_11_5, i_inst.s_fmt.imm_4_0};
    assign imm_b = {{8{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_11, i_inst.b_fmt.imm_10_5,
                    i_inst.b_fmt.imm_4_1, 1'b0};
    // upper part only, shifted by 12 downstream
    assign imm_u = i_inst.u_fmt.imm_31_12;
    // offset bit 20 drops out of the 20 bit field
    assign imm_j = {i_inst.j_fmt.imm_19_12, i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};
    assign imm_shamt = {14'd0, i_inst.i_fmt.imm_11_0[5:0]};
    // csr address sits above the rs1 / uimm field
    assign imm_csr = {3'd0, csr_addr, i_inst.i_fmt.rs1};

    always_comb begin
        if (i_class.lui || i_class.auipc) begin
            o_imm20 = imm_u;
        end else if (i_class.cond_branch) begin
            o_imm20 = imm_b;
        end else if (i_class.store) begin
            o_imm20 = imm_s;
        end else if (i_class.load || i_class.jalr) begin
            o_imm20 = imm_i;
        end else if (i_class.imm_math && i_class.shift) begin
            o_imm20 = imm_shamt;
        end else if (i_class.imm_math) begin
            o_imm20 = imm_i;
        end else if (i_class.jal) begin
            o_imm20 = imm_j;
        end else if (i_class.csr) begin
            o_imm20 = imm_csr;
        end else begin
            o_imm20 = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_classify.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_classify (
    input  rv_decode_pkg::inst_u        i_inst,
    output rv_decode_pkg::inst_class_s  o_class
);

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    logic       is_op;
    logic       is_op_32;
    logic       is_op_imm;
    logic       is_op_imm_32;
    logic       is_reg;
    logic       is_imm;
    logic       f7_zero;
    logic       f7_alt;
    logic       f7_muldiv;
    logic       left_ok;
    logic       right_ok;

    assign opcode = i_inst.r_fmt.opcode;
    assign funct3 = i_inst.r_fmt.funct3;
    assign funct7 = i_inst.r_fmt.funct7;
    // rv64 shamt is 6 bits, so only the top 6 bits of the I immediate are funct
    assign funct6 = i_inst.i_fmt.imm_11_0[11:6];

    assign is_op        = (opcode == OPC_OP);
    assign is_op_32     = (opcode == OPC_OP_32);
    assign is_op_imm    = (opcode == OPC_OP_IMM);
    assign is_op_imm_32 = (opcode == OPC_OP_IMM_32);
    assign is_reg       = is_op | is_op_32;
    assign is_imm       = is_op_imm | is_op_imm_32;

    assign f7_zero   = (funct7 == 7'b0000000);
    assign f7_alt    = (funct7 == 7'b0100000);
    assign f7_muldiv = (funct7 == 7'b0000001);

    // W shifts keep the 5 bit shamt and a full funct7
    assign left_ok  = is_op_imm ? (funct6 == 6'b000000) : f7_zero;
    assign right_ok = is_op_imm ? ((funct6 == 6'b000000) || (funct6 == 6'b010000))
                                : (f7_zero || f7_alt);

    assign o_class.add = (funct3 == 3'b000) & ((is_reg & f7_zero) | is_imm);
    assign o_class.sub = (funct3 == 3'b000) & is_reg & f7_alt;

    assign o_class.shift = (is_reg | is_imm) &
                           (((funct3 == 3'b001) & left_ok) | ((funct3 == 3'b101) & right_ok));

    // xor, or, and have no word forms
    assign o_class.logic_op = ((funct3 == 3'b100) | (funct3 == 3'b110) | (funct3 == 3'b111)) &
                              ((is_op & f7_zero) | is_op_imm);
    assign o_class.compare  = ((funct3 == 3'b010) | (funct3 == 3'b011)) &
                              ((is_op & f7_zero) | is_op_imm);

    assign o_class.cond_branch = (opcode == OPC_BRANCH) & (funct3 != 3'b010) &
                                 (funct3 != 3'b011);
    assign o_class.jal   = (opcode == OPC_JAL);
    assign o_class.jalr  = (opcode == OPC_JALR) & (funct3 == 3'b000);
    assign o_class.lui   = (opcode == OPC_LUI);
    assign o_class.auipc = (opcode == OPC_AUIPC);
    assign o_class.load  = (opcode == OPC_LOAD) & (funct3 != 3'b111);
    assign o_class.store = (opcode == OPC_STORE) & ~funct3[2];
    assign o_class.csr   = (opcode == OPC_SYSTEM) & (funct3 != 3'b000) & (funct3 != 3'b100);

    // mulh, mulhsu, mulhu have no word forms
    assign o_class.mdu = f7_muldiv & (is_op | (is_op_32 & ((funct3 == 3'b000) | funct3[2])));

    assign o_class.int_math = o_class.add | o_class.sub | o_class.shift |
                              o_class.logic_op | o_class.compare;
    assign o_class.imm_math = is_imm;

    assign o_class.unknown = ~(o_class.int_math | o_class.cond_branch | o_class.jal |
                               o_class.jalr | o_class.lui | o_class.auipc | o_class.load |
                               o_class.store | o_class.csr | o_class.mdu);

endmodule

`default_nettype wire

// ==== verilog/reg_use.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module reg_use (
    input  rv_decode_pkg::inst_u        i_inst,
    input  rv_decode_pkg::inst_class_s  i_class,
    input  logic [`RV_IMM_W-1:0]        i_imm20,
    output logic                        o_rd_wen,
    output logic [`RV_REG_IDX_W-1:0]    o_rd_idx,
    output logic [`RV_REG_IDX_W-1:0]    o_rs1_idx,
    output logic [`RV_REG_IDX_W-1:0]    o_rs2_idx,
    output logic                        o_use_imm,
    output logic                        o_is_mv
);

    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic                     rd_nz;
    logic                     writes_rd;
    logic                     reads_rs2;
    logic                     word_form;

    assign rd  = i_inst.r_fmt.rd;
    assign rs1 = i_inst.r_fmt.rs1;
    assign rs2 = i_inst.r_fmt.rs2;

    assign rd_nz = (rd != '0);

    assign writes_rd = i_class.lui | i_class.auipc | i_class.jal | i_class.jalr |
                       i_class.imm_math | i_class.int_math | i_class.csr |
                       i_class.load | i_class.mdu;
    // only register-register math reads rs2
    assign reads_rs2 = i_class.cond_branch | i_class.store | i_class.mdu |
                       (i_class.int_math & ~i_class.imm_math);

    assign o_rd_wen  = writes_rd & rd_nz;
    assign o_rd_idx  = o_rd_wen ? rd : '0;
    assign o_rs1_idx = (i_class.lui || i_class.auipc || i_class.jal) ? '0 : rs1;
    assign o_rs2_idx = reads_rs2 ? rs2 : '0;

    assign o_use_imm = i_class.imm_math & (i_imm20 != '0) & rd_nz;

    // addw / addiw live one opcode bit over and are not moves
    assign word_form = i_inst.r_fmt.opcode[3];

    assign o_is_mv = i_class.add & ~word_form & (rd == rs1) &
                     (i_class.imm_math ? (i_imm20 == '0) : (rs2 == '0));

endmodule

`default_nettype wire

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module rv_decode (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_inst_valid,
    input  logic [`RV_ILEN-1:0]         i_inst,
    output logic                        o_dec_valid,
    output rv_decode_pkg::dec_info_s    o_dec,
    output logic                        o_unknown
);

    rv_decode_pkg::inst_u       inst;
    rv_decode_pkg::inst_class_s inst_class;
    rv_decode_pkg::dec_info_s   dec_next;

    assign inst.raw = i_inst;

    inst_classify u_classify (
        .i_inst     (inst),
        .o_class    (inst_class)
    );

    imm_gen u_imm_gen (
        .i_inst     (inst),
        .i_class    (inst_class),
        .o_imm20    (dec_next.imm20)
    );

    reg_use u_reg_use (
        .i_inst     (inst),
        .i_class    (inst_class),
        .i_imm20    (dec_next.imm20),
        .o_rd_wen   (dec_next.rd_wen),
        .o_rd_idx   (dec_next.rd_idx),
        .o_rs1_idx  (dec_next.rs1_idx),
        .o_rs2_idx  (dec_next.rs2_idx),
        .o_use_imm  (dec_next.use_imm),
        .o_is_mv    (dec_next.is_mv)
    );

    uop_route u_uop_route (
        .i_inst      (inst),
        .i_class     (inst_class),
        .o_uop       (dec_next.uop),
        .o_disp_que  (dec_next.disp_que),
        .o_issue_que (dec_next.issue_que)
    );

    assign dec_next.pad = 1'b0;

    // record and unknown flag hold while no instruction is presented
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
            o_dec       <= '0;
            o_unknown   <= 1'b0;
        end else begin
            o_dec_valid <= i_inst_valid;
            if (i_inst_valid) begin
                o_dec     <= dec_next;
                o_unknown <= inst_class.unknown;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rv_decode_pkg.sv ====
`include "rv_decode_settings.svh"
`default_nettype none

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0]                imm_11_0;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0]                 imm_11_5;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_4_0;
        logic [6:0]                 opcode;
    } s_fmt_s;

    // branch offset pieces are scattered, bit 0 implied zero
    typedef struct packed {
        logic                       imm_12;
        logic [5:0]                 imm_10_5;
        logic [`RV_REG_IDX_W-1:0]   rs2;
        logic [`RV_REG_IDX_W-1:0]   rs1;
        logic [2:0]                 funct3;
        logic [3:0]                 imm_4_1;
        logic                       imm_11;
        logic [6:0]                 opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0]                imm_31_12;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } u_fmt_s;

    typedef struct packed {
        logic                       imm_20;
        logic [9:0]                 imm_10_1;
        logic                       imm_11;
        logic [7:0]                 imm_19_12;
        logic [`RV_REG_IDX_W-1:0]   rd;
        logic [6:0]                 opcode;
    } j_fmt_s;

    // one instruction word, decoded through whichever format applies
    typedef union packed {
        logic [`RV_ILEN-1:0]        raw;
        r_fmt_s                     r_fmt;
        i_fmt_s                     i_fmt;
        s_fmt_s                     s_fmt;
        b_fmt_s                     b_fmt;
        u_fmt_s                     u_fmt;
        j_fmt_s                     j_fmt;
    } inst_u;

    typedef struct packed {
        logic add;
        logic sub;
        logic shift;
        logic logic_op;
        logic compare;
        logic cond_branch;
        logic jal;
        logic jalr;
        logic lui;
        logic auipc;
        logic load;
        logic store;
        logic csr;
        logic mdu;
        // derived groups
        logic int_math;
        logic imm_math;
        logic unknown;
    } inst_class_s;

    typedef enum logic [4:0] {
        uop_none,
        uop_lui,
        uop_add,
        uop_sub,
        uop_addw,
        uop_subw,
        uop_sll,
        uop_srl,
        uop_sra,
        uop_sllw,
        uop_srlw,
        uop_sraw,
        uop_xor,
        uop_or,
        uop_and,
        uop_slt,
        uop_sltu,
        uop_mul,
        uop_mulw,
        uop_mulh,
        uop_mulhu,
        uop_mulhsu,
        uop_div,
        uop_divw,
        uop_divu,
        uop_rem,
        uop_remw,
        uop_remu,
        uop_remuw
    } uop_e;

    typedef struct packed {
        logic                       is_mv;
        logic [`RV_IMM_W-1:0]       imm20;
        logic                       rd_wen;
        logic [`RV_REG_IDX_W-1:0]   rd_idx;
        logic [`RV_REG_IDX_W-1:0]   rs1_idx;
        logic [`RV_REG_IDX_W-1:0]   rs2_idx;
        logic                       use_imm;
        logic [`RV_QUE_W-1:0]       disp_que;
        logic [`RV_QUE_W-1:0]       issue_que;
        uop_e                       uop;
        logic                       pad;
    } dec_info_s;

endpackage

`default_nettype wire

// ==== verilog/rv_decode_settings.svh ====
`ifndef RV_DECODE_SETTINGS_SVH
`define RV_DECODE_SETTINGS_SVH

`default_nettype none

// datapath widths
`define RV_ILEN         32
`define RV_REG_IDX_W    5
`define RV_IMM_W        20
`define RV_CSR_IDX_W    12
`define RV_QUE_W        2

// dispatch queue codes
`define DISP_INT        2'd0
`define DISP_MEM        2'd1
`define DISP_UNKNOWN    2'd2

// issue queue codes
`define ISSUE_ALU       2'd0
`define ISSUE_MDU       2'd1
`define ISSUE_MISC      2'd2

`default_nettype wire

`endif

// ==== verilog/uop_route.sv ====
`timescale 1ns/1ns
`include "rv_decode_settings.svh"
`default_nettype none

module uop_route (
    input  rv_decode_pkg::inst_u        i_inst,
    input  rv_decode_pkg::inst_class_s  i_class,
    output rv_decode_pkg::uop_e         o_uop,
    output logic [`RV_QUE_W-1:0]        o_disp_que,
    output logic [`RV_QUE_W-1:0]        o_issue_que
);

    logic [2:0] funct3;
    logic       word;
    logic       arith;

    assign funct3 = i_inst.r_fmt.funct3;
    // OP-32 / OP-IMM-32 differ from OP / OP-IMM only in bit 3
    assign word = i_inst.r_fmt.opcode[3];
    // funct7 bit 5, same place in the shift-immediate encoding
    assign arith = i_inst.r_fmt.funct7[5];

    always_comb begin
        o_uop = rv_decode_pkg::uop_none;
        if (i_class.lui) begin
            o_uop = rv_decode_pkg::uop_lui;
        end else if (i_class.add) begin
            o_uop = word ? rv_decode_pkg::uop_addw : rv_decode_pkg::uop_add;
        end else if (i_class.sub) begin
            o_uop = word ? rv_decode_pkg::uop_subw : rv_decode_pkg::uop_sub;
        end else if (i_class.shift) begin
            if (funct3 == 3'b001) begin
                o_uop = word ? rv_decode_pkg::uop_sllw : rv_decode_pkg::uop_sll;
            end else if (arith) begin
                o_uop = word ? rv_decode_pkg::uop_sraw : rv_decode_pkg::uop_sra;
            end else begin
                o_uop = word ? rv_decode_pkg::uop_srlw : rv_decode_pkg::uop_srl;
            end
        end else if (i_class.logic_op) begin
            case (funct3)
                3'b100:  o_uop = rv_decode_pkg::uop_xor;
                3'b110:  o_uop = rv_decode_pkg::uop_or;
                default: o_uop = rv_decode_pkg::uop_and;
            endcase
        end else if (i_class.compare) begin
            o_uop = funct3[0] ? rv_decode_pkg::uop_sltu : rv_decode_pkg::uop_slt;
        end else if (i_class.mdu) begin
            case (funct3)
                3'b000:  o_uop = word ? rv_decode_pkg::uop_mulw : rv_decode_pkg::uop_mul;
                3'b001:  o_uop = rv_decode_pkg::uop_mulh;
                3'b010:  o_uop = rv_decode_pkg::uop_mulhsu;
                3'b011:  o_uop = rv_decode_pkg::uop_mulhu;
                3'b100:  o_uop = word ? rv_decode_pkg::uop_divw : rv_decode_pkg::uop_div;
                // no divuw micro-op, divuw stays none
                3'b101:  o_uop = word ? rv_decode_pkg::uop_none : rv_decode_pkg::uop_divu;
                3'b110:  o_uop = word ? rv_decode_pkg::uop_remw : rv_decode_pkg::uop_rem;
                default: o_uop = word ? rv_decode_pkg::uop_remuw : rv_decode_pkg::uop_remu;
            endcase
        end
    end

    // unknown wins over everything
    assign o_disp_que = i_class.unknown                  ? `DISP_UNKNOWN :
                        (i_class.load || i_class.store)  ? `DISP_MEM     :
                                                           `DISP_INT;

    assign o_issue_que = (i_class.int_math || i_class.imm_math) ? `ISSUE_ALU :
                         i_class.mdu                            ? `ISSUE_MDU :
                                                                  `ISSUE_MISC;

endmodule

`default_nettype wire
